//--- verilog/csr_defs.svh
// Instruction field positions, CSR addresses, legal-bit masks and constants
// for the machine-mode CSR unit
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Data and instruction widths
`define CSR_XLEN            32
`define CSR_INST_W          32

// Instruction field positions and widths
`define CSR_RD_LSB          7
`define CSR_FUNCT3_LSB      12
`define CSR_RS1_LSB         15
`define CSR_ADDR_LSB        20
`define CSR_FUNCT3_W        3
`define CSR_REG_W           5
`define CSR_ADDR_W          12

// Machine CSR addresses
`define CSR_MSTATUS         12'h300
`define CSR_MISA            12'h301
`define CSR_MIE             12'h304
`define CSR_MTVEC           12'h305
`define CSR_MSCRATCH        12'h340
`define CSR_MEPC            12'h341
`define CSR_MCAUSE          12'h342
`define CSR_MIP             12'h344
`define CSR_MHARTID         12'hF14

// Legal mstatus bits: 31, 22:11, 8:7, 5:3, 1:0
`define CSR_MSTATUS_MASK    32'h807F_F9BB
// RV32I, MXL = 1
`define CSR_MISA_VALUE      32'h4000_0100
`define CSR_HART_ID         32'h0000_0000

// Interrupt enable and pending bit positions
`define CSR_MIE_BIT         3
`define CSR_MEI_BIT         11

`endif

//--- verilog/csr_pkg.sv
// Shared types of the CSR unit: execution FSM states and Zicsr funct3 codes
`include "csr_defs.svh"

package csr_pkg;

    ////////////////////////////////////////////////////////////
    // Execution FSM
    ////////////////////////////////////////////////////////////

    // Accept, compute and write back, then one store cycle
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        COMPUTE = 2'd1,
        STORE   = 2'd2
    } csr_state_t;

    ////////////////////////////////////////////////////////////
    // Zicsr operations, funct3 encoding
    ////////////////////////////////////////////////////////////

    // Bit 2 set selects the immediate (zimm) forms
    typedef enum logic [`CSR_FUNCT3_W-1:0] {
        CSRRW  = 3'd1,
        CSRRS  = 3'd2,
        CSRRC  = 3'd3,
        CSRRWI = 3'd5,
        CSRRSI = 3'd6,
        CSRRCI = 3'd7
    } csr_op_t;

endpackage

//--- verilog/csr_access_if.sv
// CSR read and write bus between the execution FSM, the register file
// and the interrupt block
`timescale 1ns/1ps
`include "csr_defs.svh"

interface csr_access_if;

    // Combinational read port
    logic [`CSR_ADDR_W-1:0] rd_addr;
    logic [`CSR_XLEN-1:0]   rd_data;

    // Single-cycle write pulse
    logic                   wr_en;
    logic [`CSR_ADDR_W-1:0] wr_addr;
    logic [`CSR_XLEN-1:0]   wr_data;

    modport exec (output rd_addr, input rd_data, output wr_en, output wr_addr,
                  output wr_data);

    modport regfile (input rd_addr, output rd_data, input wr_en, input wr_addr,
                     input wr_data);

    // mip lives in the interrupt block, it only listens to writes
    modport irq (input wr_en, input wr_addr, input wr_data);

endinterface

//--- verilog/csr_exec.sv
// Zicsr instruction execution: acceptance, operand capture and the
// read-modify-write FSM driving the CSR bus and the rd write port
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_exec (
    input  logic                    aclk,
    input  logic                    aresetn,
    // Instruction handshake
    input  logic                    valid,
    output logic                    ready,
    input  logic [`CSR_INST_W-1:0]  instbus,
    // rs1 lookup
    output logic [`CSR_REG_W-1:0]   rs1_addr,
    input  logic [`CSR_XLEN-1:0]    rs1_val,
    // rd write-back
    output logic                    rd_wr_en,
    output logic [`CSR_REG_W-1:0]   rd_wr_addr,
    output logic [`CSR_XLEN-1:0]    rd_wr_val,
    // CSR bus
    csr_access_if.exec              acc
);

    import csr_pkg::*;

    csr_state_t                 state;

    // Instruction fields
    logic [`CSR_FUNCT3_W-1:0]   f_funct3;
    logic [`CSR_ADDR_W-1:0]     f_addr;
    logic [`CSR_REG_W-1:0]      f_rs1;
    logic [`CSR_REG_W-1:0]      f_rd;

    // Captured at acceptance
    logic [`CSR_FUNCT3_W-1:0]   funct3_r;
    logic [`CSR_ADDR_W-1:0]     addr_r;
    logic [`CSR_REG_W-1:0]      rs1_idx_r;
    logic [`CSR_XLEN-1:0]       rs1_val_r;
    logic [`CSR_XLEN-1:0]       old_r;

    logic                       accept;
    logic [`CSR_XLEN-1:0]       operand;
    logic [`CSR_XLEN-1:0]       new_val;
    logic                       csr_we;
    logic                       op_valid;
    logic                       csr_wr_q;
    logic [`CSR_XLEN-1:0]       csr_wdata_q;

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    assign f_funct3 = instbus[`CSR_FUNCT3_LSB +: `CSR_FUNCT3_W];
    assign f_addr   = instbus[`CSR_ADDR_LSB +: `CSR_ADDR_W];
    assign f_rs1    = instbus[`CSR_RS1_LSB +: `CSR_REG_W];
    assign f_rd     = instbus[`CSR_RD_LSB +: `CSR_REG_W];

    // Core looks up rs1 straight from the instruction
    assign rs1_addr = f_rs1;
    assign accept   = (state == IDLE) && valid && ready;

    // Old value read combinationally, from the instruction while idle
    assign acc.rd_addr = (state == IDLE) ? f_addr : addr_r;

    ////////////////////////////////////////////////////////////
    // New value
    ////////////////////////////////////////////////////////////

    // Immediate forms take zero-extended zimm (the rs1 field)
    assign operand = funct3_r[2] ? {{(`CSR_XLEN-`CSR_REG_W){1'b0}}, rs1_idx_r}
                                 : rs1_val_r;

    always_comb begin
        new_val  = old_r;
        csr_we   = 1'b0;
        op_valid = 1'b1;
        case (funct3_r)
            CSRRW, CSRRWI: begin
                new_val = operand;
                csr_we  = 1'b1;
            end
            CSRRS, CSRRSI: begin
                new_val = old_r | operand;
                // x0 or zimm of zero means read only
                csr_we  = (rs1_idx_r != '0);
            end
            CSRRC, CSRRCI: begin
                new_val = old_r & ~operand;
                csr_we  = (rs1_idx_r != '0);
            end
            // Reserved funct3, no rd and no CSR write
            default: op_valid = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= IDLE;
            ready    <= 1'b0;
            rd_wr_en <= 1'b0;
            csr_wr_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    ready <= 1'b1;
                    if (accept) begin
                        ready <= 1'b0;
                        state <= COMPUTE;
                    end
                end
                COMPUTE: begin
                    // rd and CSR writes pulse together
                    rd_wr_en <= op_valid;
                    csr_wr_q <= csr_we;
                    state    <= STORE;
                end
                STORE: begin
                    rd_wr_en <= 1'b0;
                    csr_wr_q <= 1'b0;
                    ready    <= 1'b1;
                    state    <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Operand and result registers
    always_ff @(posedge aclk) begin
        if (accept) begin
            funct3_r   <= f_funct3;
            addr_r     <= f_addr;
            rs1_idx_r  <= f_rs1;
            rs1_val_r  <= rs1_val;
            rd_wr_addr <= f_rd;
            old_r      <= acc.rd_data;
        end
        if (state == COMPUTE) begin
            rd_wr_val   <= old_r;
            csr_wdata_q <= new_val;
        end
    end

    assign acc.wr_en   = csr_wr_q;
    assign acc.wr_addr = addr_r;
    assign acc.wr_data = csr_wdata_q;

endmodule

//--- verilog/csr_regfile.sv
// Machine CSR storage, read mux, trap-side writes and the shared
// mtvec, mepc and mstatus outputs
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_regfile (
    input  logic                    aclk,
    input  logic                    aresetn,
    // CSR bus
    csr_access_if.regfile           acc,
    // Trap-side writes from the core
    input  logic                    ctrl_mepc_wr,
    input  logic [`CSR_XLEN-1:0]    ctrl_mepc,
    input  logic                    ctrl_mstatus_wr,
    input  logic [`CSR_XLEN-1:0]    ctrl_mstatus,
    input  logic                    ctrl_mcause_wr,
    input  logic [`CSR_XLEN-1:0]    ctrl_mcause,
    // Pending word from the interrupt block
    input  logic [`CSR_XLEN-1:0]    mip,
    // Enables towards the interrupt block
    output logic                    mstatus_mie,
    output logic                    mie_meie,
    // Shared CSR outputs
    output logic [`CSR_XLEN-1:0]    csr_mtvec,
    output logic [`CSR_XLEN-1:0]    csr_mepc,
    output logic [`CSR_XLEN-1:0]    csr_mstatus
);

    import csr_pkg::*;

    logic [`CSR_XLEN-1:0]   mstatus;
    logic [`CSR_XLEN-1:0]   mie;
    logic [`CSR_XLEN-1:0]   mtvec;
    logic [`CSR_XLEN-1:0]   mscratch;
    logic [`CSR_XLEN-1:0]   mepc;
    logic [`CSR_XLEN-1:0]   mcause;

    // Per-register write decode
    logic   wr_mstatus;
    logic   wr_mie;
    logic   wr_mtvec;
    logic   wr_mscratch;
    logic   wr_mepc;
    logic   wr_mcause;

    assign wr_mstatus  = acc.wr_en && (acc.wr_addr == `CSR_MSTATUS);
    assign wr_mie      = acc.wr_en && (acc.wr_addr == `CSR_MIE);
    assign wr_mtvec    = acc.wr_en && (acc.wr_addr == `CSR_MTVEC);
    assign wr_mscratch = acc.wr_en && (acc.wr_addr == `CSR_MSCRATCH);
    assign wr_mepc     = acc.wr_en && (acc.wr_addr == `CSR_MEPC);
    assign wr_mcause   = acc.wr_en && (acc.wr_addr == `CSR_MCAUSE);

    ////////////////////////////////////////////////////////////
    // Trap state, core strobes win over CSR writes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mstatus <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else begin
            // Only legal mstatus bits are kept
            if (ctrl_mstatus_wr) begin
                mstatus <= ctrl_mstatus & `CSR_MSTATUS_MASK;
            end else if (wr_mstatus) begin
                mstatus <= acc.wr_data & `CSR_MSTATUS_MASK;
            end
            // IALIGN=32, low two bits forced to zero
            if (ctrl_mepc_wr) begin
                mepc <= {ctrl_mepc[`CSR_XLEN-1:2], 2'b00};
            end else if (wr_mepc) begin
                mepc <= {acc.wr_data[`CSR_XLEN-1:2], 2'b00};
            end
            if (ctrl_mcause_wr) begin
                mcause <= ctrl_mcause;
            end else if (wr_mcause) begin
                mcause <= acc.wr_data;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Software-only registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
        end else begin
            if (wr_mie) begin
                mie <= acc.wr_data;
            end
            if (wr_mtvec) begin
                mtvec <= acc.wr_data;
            end
            if (wr_mscratch) begin
                mscratch <= acc.wr_data;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////////////////////////

    // misa and mhartid are constants, unknown addresses read zero
    always_comb begin
        case (acc.rd_addr)
            `CSR_MSTATUS:  acc.rd_data = mstatus;
            `CSR_MISA:     acc.rd_data = `CSR_MISA_VALUE;
            `CSR_MIE:      acc.rd_data = mie;
            `CSR_MTVEC:    acc.rd_data = mtvec;
            `CSR_MSCRATCH: acc.rd_data = mscratch;
            `CSR_MEPC:     acc.rd_data = mepc;
            `CSR_MCAUSE:   acc.rd_data = mcause;
            `CSR_MIP:      acc.rd_data = mip;
            `CSR_MHARTID:  acc.rd_data = `CSR_HART_ID;
            default:       acc.rd_data = '0;
        endcase
    end

    // Shared outputs and interrupt enables
    assign csr_mtvec   = mtvec;
    assign csr_mepc    = mepc;
    assign csr_mstatus = mstatus;
    assign mstatus_mie = mstatus[`CSR_MIE_BIT];
    assign mie_meie    = mie[`CSR_MEI_BIT];

endmodule

//--- verilog/csr_irq.sv
// External interrupt synchronizer and the mip register
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_irq (
    input  logic                    aclk,
    input  logic                    aresetn,
    // Asynchronous external interrupt pin
    input  logic                    eirq,
    // Enables from mstatus and mie
    input  logic                    mstatus_mie,
    input  logic                    mie_meie,
    // CSR writes to mip
    csr_access_if.irq               acc,
    output logic [`CSR_XLEN-1:0]    mip
);

    import csr_pkg::*;

    logic [1:0] eirq_sync;
    logic       meip;
    logic       meip_set;
    logic       mip_wr;

    // Two-flop synchronizer into aclk
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            eirq_sync <= 2'b00;
        end else begin
            eirq_sync <= {eirq_sync[0], eirq};
        end
    end

    assign meip_set = eirq_sync[1] && mstatus_mie && mie_meie;
    assign mip_wr   = acc.wr_en && (acc.wr_addr == `CSR_MIP);

    // Pending set wins over a software clear at the same edge
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            meip <= 1'b0;
        end else if (meip_set) begin
            meip <= 1'b1;
        end else if (mip_wr) begin
            meip <= acc.wr_data[`CSR_MEI_BIT];
        end
    end

    // Timer and software pending bits are not implemented
    always_comb begin
        mip = '0;
        mip[`CSR_MEI_BIT] = meip;
    end

endmodule

//--- verilog/csr_unit.sv
// Machine-mode CSR unit top level: execution FSM, register file and
// interrupt block on one CSR bus
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_unit (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic                    eirq,
    // Instruction handshake
    input  logic                    valid,
    output logic                    ready,
    input  logic [`CSR_INST_W-1:0]  instbus,
    // Register file ports of the core
    output logic [`CSR_REG_W-1:0]   rs1_addr,
    input  logic [`CSR_XLEN-1:0]    rs1_val,
    output logic                    rd_wr_en,
    output logic [`CSR_REG_W-1:0]   rd_wr_addr,
    output logic [`CSR_XLEN-1:0]    rd_wr_val,
    // Trap-side writes
    input  logic                    ctrl_mepc_wr,
    input  logic [`CSR_XLEN-1:0]    ctrl_mepc,
    input  logic                    ctrl_mstatus_wr,
    input  logic [`CSR_XLEN-1:0]    ctrl_mstatus,
    input  logic                    ctrl_mcause_wr,
    input  logic [`CSR_XLEN-1:0]    ctrl_mcause,
    // Shared CSR outputs
    output logic [`CSR_XLEN-1:0]    csr_mtvec,
    output logic [`CSR_XLEN-1:0]    csr_mepc,
    output logic [`CSR_XLEN-1:0]    csr_mstatus,
    output logic                    csr_meip
);

    logic [`CSR_XLEN-1:0]   mip;
    logic                   mstatus_mie;
    logic                   mie_meie;

    // Internal CSR bus
    csr_access_if csr_bus ();

    csr_exec u_exec (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .valid      (valid),
        .ready      (ready),
        .instbus    (instbus),
        .rs1_addr   (rs1_addr),
        .rs1_val    (rs1_val),
        .rd_wr_en   (rd_wr_en),
        .rd_wr_addr (rd_wr_addr),
        .rd_wr_val  (rd_wr_val),
        .acc        (csr_bus.exec)
    );

    csr_regfile u_regfile (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .acc             (csr_bus.regfile),
        .ctrl_mepc_wr    (ctrl_mepc_wr),
        .ctrl_mepc       (ctrl_mepc),
        .ctrl_mstatus_wr (ctrl_mstatus_wr),
        .ctrl_mstatus    (ctrl_mstatus),
        .ctrl_mcause_wr  (ctrl_mcause_wr),
        .ctrl_mcause     (ctrl_mcause),
        .mip             (mip),
        .mstatus_mie     (mstatus_mie),
        .mie_meie        (mie_meie),
        .csr_mtvec       (csr_mtvec),
        .csr_mepc        (csr_mepc),
        .csr_mstatus     (csr_mstatus)
    );

    csr_irq u_irq (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .eirq        (eirq),
        .mstatus_mie (mstatus_mie),
        .mie_meie    (mie_meie),
        .acc         (csr_bus.irq),
        .mip         (mip)
    );

    // Machine external interrupt pending
    assign csr_meip = mip[`CSR_MEI_BIT];

endmodule

//--- sim/csr_checker.sv
// Testbench checker for the CSR unit that watches the rs1 lookup, rd write-back
// and the shared outputs and compares them with the expected values of each test
`timescale 1ns/1ps

module csr_checker (
    input logic        aclk,
    input logic        valid,
    input logic        ready,
    input logic [4:0]  rs1_addr,
    input logic        rd_wr_en,
    input logic [4:0]  rd_wr_addr,
    input logic [31:0] rd_wr_val,
    input logic [31:0] csr_mtvec,
    input logic [31:0] csr_mepc,
    input logic [31:0] csr_mstatus,
    input logic        csr_meip
);

    int          pass_count = 0;
    int          fail_count = 0;
    int          rd_count   = 0;
    int          busy_count = 0;
    logic [4:0]  rs1_addr_seen;
    logic [4:0]  rd_addr_seen;
    logic [31:0] rd_val_seen;

    // rs1 index at the accept edge, busy cycles and every rd write-back pulse
    always @(posedge aclk) begin
        if (valid && ready) begin
            rs1_addr_seen = rs1_addr;
        end
        if (!ready) begin
            busy_count = busy_count + 1;
        end
        if (rd_wr_en) begin
            rd_count     = rd_count + 1;
            rd_addr_seen = rd_wr_addr;
            rd_val_seen  = rd_wr_val;
        end
    end

    // Start of a new test
    task automatic arm();
        rd_count      = 0;
        busy_count    = 0;
        rs1_addr_seen = 'x;
    endtask

    task automatic compare_word(input string name, input string what,
                                input logic [31:0] exp, input logic [31:0] act,
                                inout logic ok);
        if (exp !== act) begin
            $display("Error %s: %s expected %08h actual %08h", name, what, exp, act);
            ok = 1'b0;
        end
    endtask

    task automatic check_test(input string name, input logic exp_rd_en,
                              input logic [4:0] exp_rs1, input logic [4:0] exp_rd_addr,
                              input logic [31:0] exp_rd, input logic [31:0] exp_mtvec,
                              input logic [31:0] exp_mepc, input logic [31:0] exp_mstatus,
                              input logic exp_meip);
        logic ok;
        ok = 1'b1;
        // Exactly one rd pulse per instruction and none after reset
        if (exp_rd_en && rd_count == 0) begin
            $display("%s: no rd write seen", name);
            ok = 1'b0;
        end else if (exp_rd_en && rd_count > 1) begin
            $display("%s: rd written more than once", name);
            ok = 1'b0;
        end else if (!exp_rd_en && rd_count != 0) begin
            $display("%s: unexpected rd write", name);
            ok = 1'b0;
        end else if (exp_rd_en) begin
            compare_word(name, "rs1 addr", {27'd0, exp_rs1}, {27'd0, rs1_addr_seen}, ok);
            compare_word(name, "rd addr", {27'd0, exp_rd_addr}, {27'd0, rd_addr_seen}, ok);
            compare_word(name, "rd", exp_rd, rd_val_seen, ok);
            // Busy from acceptance until the update lands
            if (busy_count != 2) begin
                $display("%s: ready was low for %0d cycles instead of 2", name, busy_count);
                ok = 1'b0;
            end
        end
        compare_word(name, "mtvec", exp_mtvec, csr_mtvec, ok);
        compare_word(name, "mepc", exp_mepc, csr_mepc, ok);
        compare_word(name, "mstatus", exp_mstatus, csr_mstatus, ok);
        compare_word(name, "meip", {31'd0, exp_meip}, {31'd0, csr_meip}, ok);
        if (ok) begin
            $display("ok    %s", name);
            pass_count = pass_count + 1;
        end else begin
            fail_count = fail_count + 1;
        end
    endtask

endmodule

//--- sim/csr_unit_tb.sv
// Testbench top for the CSR unit with clock, reset, stimulus table,
// reference model, watchdog and final summary
`timescale 1ns/1ps

module csr_unit_tb;

    import csr_pkg::*;

    typedef struct {
        string   name;
        csr_op_t op;
        logic [11:0] addr;
        logic [4:0]  idx;
        logic [4:0]  rd;
        logic        rnd;
        logic [31:0] val;
        int          ctrl;
        logic        irq;
    } row_t;

    logic aclk, aresetn, eirq, valid, ready;
    logic [31:0] instbus, rs1_val, rd_wr_val, ctrl_mepc, ctrl_mstatus, ctrl_mcause;
    logic [31:0] csr_mtvec, csr_mepc, csr_mstatus;
    logic [4:0]  rs1_addr, rd_wr_addr;
    logic rd_wr_en, ctrl_mepc_wr, ctrl_mstatus_wr, ctrl_mcause_wr, csr_meip;

    row_t        rows[$];
    logic [31:0] seed = 32'h1987;
    // Reference model of the machine CSRs
    logic [31:0] m_mstatus, m_mie, m_mtvec, m_mscratch, m_mepc, m_mcause;
    logic        m_meip;

    csr_unit dut (.*);

    csr_checker chk (.aclk(aclk), .valid(valid), .ready(ready), .rs1_addr(rs1_addr),
                     .rd_wr_en(rd_wr_en), .rd_wr_addr(rd_wr_addr),
                     .rd_wr_val(rd_wr_val), .csr_mtvec(csr_mtvec), .csr_mepc(csr_mepc),
                     .csr_mstatus(csr_mstatus), .csr_meip(csr_meip));

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    function automatic logic [31:0] xorshift();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic logic [31:0] read_model(input logic [11:0] a);
        case (a)
            12'h300: return m_mstatus;
            12'h301: return 32'h4000_0100;
            12'h304: return m_mie;
            12'h305: return m_mtvec;
            12'h340: return m_mscratch;
            12'h341: return m_mepc;
            12'h342: return m_mcause;
            12'h344: return {20'd0, m_meip, 11'd0};
            12'hF14: return 32'h0000_0000;
            default: return 32'd0;
        endcase
    endfunction

    // Legal mstatus bits and word-aligned mepc
    task automatic write_model(input logic [11:0] a, input logic [31:0] d);
        case (a)
            12'h300: m_mstatus  = d & 32'h807F_F9BB;
            12'h304: m_mie      = d;
            12'h305: m_mtvec    = d;
            12'h340: m_mscratch = d;
            12'h341: m_mepc     = {d[31:2], 2'b00};
            12'h342: m_mcause   = d;
            12'h344: m_meip     = d[11];
            default: ;
        endcase
    endtask

    task automatic add_row(input string n, input csr_op_t op, input logic [11:0] a,
                           input logic [4:0] idx, input logic rnd, input logic [31:0] v,
                           input int ctrl, input logic irq);
        row_t r;
        r.name = n;
        r.op   = op;
        r.addr = a;
        r.idx  = idx;
        // rd never equals the rs1 index
        r.rd   = idx + 5'd9;
        r.rnd  = rnd;
        r.val  = v;
        r.ctrl = ctrl;
        r.irq  = irq;
        rows.push_back(r);
    endtask

    task automatic run_row(input row_t r);
        logic [31:0] opnd, old, nv;
        // Pin change settles through the synchronizer
        if (eirq !== r.irq) begin
            eirq = r.irq;
            repeat (4) @(negedge aclk);
        end
        if (eirq && m_mstatus[3] && m_mie[11]) m_meip = 1'b1;
        // Trap-side strobe for one cycle
        if (r.ctrl != 0) begin
            ctrl_mepc_wr    = (r.ctrl == 1);
            ctrl_mstatus_wr = (r.ctrl == 2);
            ctrl_mcause_wr  = (r.ctrl == 3);
            ctrl_mepc       = r.val;
            ctrl_mstatus    = r.val;
            ctrl_mcause     = r.val;
            @(negedge aclk);
            ctrl_mepc_wr    = 1'b0;
            ctrl_mstatus_wr = 1'b0;
            ctrl_mcause_wr  = 1'b0;
            if (r.ctrl == 1) m_mepc = {r.val[31:2], 2'b00};
            if (r.ctrl == 2) m_mstatus = r.val & 32'h807F_F9BB;
            if (r.ctrl == 3) m_mcause = r.val;
        end
        while (!ready) @(negedge aclk);
        chk.arm();
        rs1_val = r.rnd ? xorshift() : r.val;
        instbus = {r.addr, r.idx, r.op, r.rd, 7'h73};
        valid   = 1'b1;
        old     = read_model(r.addr);
        @(negedge aclk);
        valid = 1'b0;
        while (!ready) @(negedge aclk);
        repeat (2) @(negedge aclk);
        // Immediate forms use the zero-extended zimm
        opnd = r.op[2] ? {27'd0, r.idx} : rs1_val;
        case (r.op)
            CSRRS, CSRRSI: nv = old | opnd;
            CSRRC, CSRRCI: nv = old & ~opnd;
            default:       nv = opnd;
        endcase
        // Set and clear with x0 or zimm zero only read
        if (r.op == CSRRW || r.op == CSRRWI || r.idx != 0) write_model(r.addr, nv);
        if (eirq && m_mstatus[3] && m_mie[11]) m_meip = 1'b1;
        chk.check_test(r.name, 1'b1, r.idx, r.rd, old, m_mtvec, m_mepc, m_mstatus,
                       m_meip);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////
    initial begin
        add_row("rw_mscratch",  CSRRW,  12'h340, 5'd1,  0, 32'h1234_5678, 0, 0);
        add_row("rwi_mscratch", CSRRWI, 12'h340, 5'd31, 0, 32'h0, 0, 0);
        add_row("rw_mtvec",     CSRRW,  12'h305, 5'd2,  1, 32'h0, 0, 0);
        add_row("rwi_mtvec",    CSRRWI, 12'h305, 5'd4,  0, 32'h0, 0, 0);
        add_row("rs_mscratch",  CSRRS,  12'h340, 5'd3,  1, 32'h0, 0, 0);
        add_row("rc_mscratch",  CSRRC,  12'h340, 5'd4,  1, 32'h0, 0, 0);
        add_row("rs_x0",        CSRRS,  12'h340, 5'd0,  1, 32'h0, 0, 0);
        add_row("rsi_mtvec",    CSRRSI, 12'h305, 5'd19, 0, 32'h0, 0, 0);
        add_row("rci_mtvec",    CSRRCI, 12'h305, 5'd6,  0, 32'h0, 0, 0);
        add_row("rci_zero",     CSRRCI, 12'h305, 5'd0,  0, 32'h0, 0, 0);
        add_row("rw_mstatus",   CSRRW,  12'h300, 5'd1,  0, 32'hFFFF_FFFF, 0, 0);
        add_row("rw_mepc",      CSRRW,  12'h341, 5'd1,  0, 32'hDEAD_BEEF, 0, 0);
        add_row("rw_misa",      CSRRW,  12'h301, 5'd1,  0, 32'hFFFF_FFFF, 0, 0);
        add_row("rs_misa",      CSRRS,  12'h301, 5'd0,  0, 32'h0, 0, 0);
        add_row("rw_mhartid",   CSRRW,  12'hF14, 5'd1,  0, 32'h5, 0, 0);
        add_row("rs_mhartid",   CSRRS,  12'hF14, 5'd0,  0, 32'h0, 0, 0);
        add_row("rw_unknown",   CSRRW,  12'h7C0, 5'd1,  1, 32'h0, 0, 0);
        add_row("rs_unknown",   CSRRS,  12'h7C0, 5'd0,  0, 32'h0, 0, 0);
        add_row("trap_mepc",    CSRRS,  12'h341, 5'd0,  0, 32'h8000_0007, 1, 0);
        add_row("trap_mstatus", CSRRS,  12'h300, 5'd0,  0, 32'hFFFF_FFFF, 2, 0);
        add_row("trap_mcause",  CSRRS,  12'h342, 5'd0,  0, 32'h8000_000B, 3, 0);
        add_row("clr_mie_bit",  CSRRCI, 12'h300, 5'd8,  0, 32'h0, 0, 0);
        add_row("rw_mie",       CSRRW,  12'h304, 5'd1,  0, 32'h0000_0800, 0, 0);
        add_row("irq_masked",   CSRRS,  12'h344, 5'd0,  0, 32'h0, 0, 1);
        add_row("set_mie_bit",  CSRRSI, 12'h300, 5'd8,  0, 32'h0, 0, 1);
        add_row("irq_pending",  CSRRS,  12'h344, 5'd0,  0, 32'h0, 0, 1);
        add_row("clr_mip",      CSRRW,  12'h344, 5'd1,  0, 32'h0, 0, 0);
        add_row("irq_raise",    CSRRS,  12'h344, 5'd0,  0, 32'h0, 0, 1);
    end

    initial begin
        {m_mstatus, m_mie, m_mtvec, m_mscratch, m_mepc, m_mcause} = '0;
        m_meip          = 1'b0;
        aresetn         = 1'b0;
        eirq            = 1'b0;
        valid           = 1'b0;
        instbus         = '0;
        rs1_val         = '0;
        ctrl_mepc_wr    = 1'b0;
        ctrl_mstatus_wr = 1'b0;
        ctrl_mcause_wr  = 1'b0;
        ctrl_mepc       = '0;
        ctrl_mstatus    = '0;
        ctrl_mcause     = '0;
        chk.arm();
        repeat (8) @(negedge aclk);
        aresetn = 1'b1;
        while (!ready) @(negedge aclk);
        chk.check_test("reset", 1'b0, 5'd0, 5'd0, 32'd0, 32'd0, 32'd0, 32'd0, 1'b0);
        foreach (rows[i]) run_row(rows[i]);
        $display("Summary: %0d passed, %0d failed", chk.pass_count, chk.fail_count);
        if (chk.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog allows 20 cycles per row plus reset
    initial begin
        #1;
        #((rows.size() * 20 + 8 + 10) * 10);
        $display("Timeout: the DUT did not finish the tests in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- src.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_access_if.sv
verilog/csr_exec.sv
verilog/csr_regfile.sv
verilog/csr_irq.sv
verilog/csr_unit.sv
sim/csr_checker.sv
sim/csr_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= csr_unit_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
